/* list.f */
+incdir+.
spd_pkg.sv
spd_sequencer.sv
spd_byte_regs.sv
mtb_divider.sv
spd_decode.sv
spd_reader_top.sv
spd_reader_sva.sv
tb_clk_gen.sv
tb_spd_reader.sv

/* mtb_divider.sv */
`timescale 1ns/1ns
`include "spd_cfg.svh"

module mtb_divider (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic [`SPD_DW-1:0]    i_dividend,
    input  logic [`SPD_DW-1:0]    i_divisor,
    output logic                  o_done,
    output logic [`SPD_MTB_W-1:0] o_quot
);

    localparam int PW = `SPD_DW + `SPD_MTB_W;   // dividend x 1000 fits here
    localparam int CW = $clog2(`SPD_MTB_W);

    // one restoring step returns {quotient bit, new remainder}
    function automatic logic [`SPD_DW:0] div_step(input logic [`SPD_DW-1:0] r,
                                                  input logic b,
                                                  input logic [`SPD_DW-1:0] d);
        logic [`SPD_DW:0] sh;
        sh = {r, b};
        if (sh >= {1'b0, d})
            div_step = {1'b1, `SPD_DW'(sh - {1'b0, d})};
        else
            div_step = {1'b0, sh[`SPD_DW-1:0]};
    endfunction

    logic [PW-1:0]         product;
    logic [`SPD_DW-1:0]    rem0, rem, div_r;
    logic [`SPD_DW:0]      first, nxt;
    logic [`SPD_MTB_W-1:0] bits;    // dividend bits shift out, quotient bits shift in
    logic [CW-1:0]         cnt;
    logic                  busy;

    assign product = i_dividend * PW'(1000);
    // bits above the kept quotient only set the starting remainder
    assign rem0    = (i_divisor == '0) ? '0 : product[PW-1:`SPD_MTB_W] % i_divisor;
    assign first   = div_step(rem0, product[`SPD_MTB_W-1], i_divisor);
    assign nxt     = div_step(rem, bits[`SPD_MTB_W-1], div_r);
    assign o_quot  = bits;   // a zero divisor gives all ones

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= CW'(`SPD_MTB_W - 1);   // first bit is done on the load
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CW'(1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            div_r <= i_divisor;
            rem   <= first[`SPD_DW-1:0];
            bits  <= {product[`SPD_MTB_W-2:0], first[`SPD_DW]};
        end else if (busy) begin
            rem  <= nxt[`SPD_DW-1:0];
            bits <= {bits[`SPD_MTB_W-2:0], nxt[`SPD_DW]};
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_spd_reader -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

/* spd_byte_regs.sv */
`timescale 1ns/1ns
`include "spd_cfg.svh"

module spd_byte_regs (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_cap_en,
    input  logic [`SPD_IDX_W-1:0] i_cap_idx,
    input  logic [`SPD_DW-1:0]    i_cap_data,
    output spd_pkg::spd_bytes_t   o_bytes
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bytes <= '0;
        end else if (i_cap_en) begin
            case (i_cap_idx)
                `SPD_IDX_W'(`SPD_BYTE_TYPE):         o_bytes.dram_type    <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_MODULE):       o_bytes.module_type  <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_DENSITY):      o_bytes.density      <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_ADDRESSING):   o_bytes.addressing   <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_ORG):          o_bytes.org          <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_BUSW):         o_bytes.bus_width    <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_MTB_DIVIDEND): o_bytes.mtb_dividend <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_MTB_DIVISOR):  o_bytes.mtb_divisor  <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_TRCD):         o_bytes.trcd         <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_TRP):          o_bytes.trp          <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_TRAS_HI):      o_bytes.tras_hi      <= i_cap_data;
                `SPD_IDX_W'(`SPD_BYTE_TRAS_LO):      o_bytes.tras_lo      <= i_cap_data;
                default: o_bytes <= o_bytes;   // unused spd bytes
            endcase
        end
    end

endmodule

/* spd_cfg.svh */
`ifndef SPD_CFG_SVH
`define SPD_CFG_SVH

`define SPD_DEV_AW            7
`define SPD_REG_AW            8
`define SPD_DW                8
`define SPD_IDX_W             5     // enough for indices 0..SPD_LAST_BYTE
`define SPD_ADDR_FIRST        1     // address 0 is the general call
`define SPD_ADDR_LAST         127
`define SPD_LAST_BYTE         22
`define SPD_MTB_W             10
`define SPD_DDR3_TYPE         8'h0B

// spd byte offsets
`define SPD_BYTE_TYPE         2
`define SPD_BYTE_MODULE       3
`define SPD_BYTE_DENSITY      4
`define SPD_BYTE_ADDRESSING   5
`define SPD_BYTE_ORG          7
`define SPD_BYTE_BUSW         8
`define SPD_BYTE_MTB_DIVIDEND 10
`define SPD_BYTE_MTB_DIVISOR  11
`define SPD_BYTE_TRCD         18
`define SPD_BYTE_TRP          20
`define SPD_BYTE_TRAS_HI      21
`define SPD_BYTE_TRAS_LO      22

`endif

/* spd_decode.sv */
`timescale 1ns/1ns
`include "spd_cfg.svh"

module spd_decode (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  spd_pkg::spd_bytes_t    i_bytes,
    input  logic [`SPD_DEV_AW-1:0] i_dev_addr,
    input  logic                   i_mtb_done,
    input  logic [`SPD_MTB_W-1:0]  i_mtb_ps,
    output logic                   o_done,
    output spd_pkg::spd_params_t   o_params
);

    spd_pkg::spd_params_t dec;

    always_comb begin
        dec.dev_addr    = i_dev_addr;
        dec.is_ddr3     = (i_bytes.dram_type == `SPD_DDR3_TYPE);
        dec.module_type = i_bytes.module_type[3:0];
        dec.ba_bits     = {1'b0, i_bytes.density[6:4]} + 4'd3;
        dec.density     = i_bytes.density[3:0];
        dec.row_bits    = {2'b00, i_bytes.addressing[5:3]} + 5'd12;
        dec.col_bits    = {1'b0, i_bytes.addressing[2:0]} + 4'd9;
        dec.dual_rank   = (i_bytes.org[5:3] == 3'd1);         // rank field is ranks - 1
        dec.byte_lanes  = 4'd1 << i_bytes.bus_width[1:0];
        dec.mtb_ps      = i_mtb_ps;
        dec.trcd        = i_bytes.trcd;
        dec.trp         = i_bytes.trp;
        dec.tras        = {i_bytes.tras_hi[3:0], i_bytes.tras_lo};
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_done   <= 1'b0;
            o_params <= '0;
        end else if (i_mtb_done) begin
            o_done   <= 1'b1;   // sticky until reset
            o_params <= dec;
        end
    end

endmodule

/* spd_pkg.sv */
`include "spd_cfg.svh"

package spd_pkg;

    typedef struct packed {
        logic [`SPD_DEV_AW-1:0] dev_addr;
        logic [`SPD_REG_AW-1:0] reg_addr;
    } i2c_cmd_t;

    typedef struct packed {
        logic [`SPD_DW-1:0] data;
        logic               nack;
    } i2c_rsp_t;

    // only the bytes the decoder looks at
    typedef struct packed {
        logic [`SPD_DW-1:0] dram_type;
        logic [`SPD_DW-1:0] module_type;
        logic [`SPD_DW-1:0] density;
        logic [`SPD_DW-1:0] addressing;
        logic [`SPD_DW-1:0] org;
        logic [`SPD_DW-1:0] bus_width;
        logic [`SPD_DW-1:0] mtb_dividend;
        logic [`SPD_DW-1:0] mtb_divisor;
        logic [`SPD_DW-1:0] trcd;
        logic [`SPD_DW-1:0] trp;
        logic [`SPD_DW-1:0] tras_hi;
        logic [`SPD_DW-1:0] tras_lo;
    } spd_bytes_t;

    typedef struct packed {
        logic [`SPD_DEV_AW-1:0] dev_addr;
        logic                   is_ddr3;
        logic [3:0]             module_type;
        logic [3:0]             ba_bits;
        logic [3:0]             density;
        logic [4:0]             row_bits;
        logic [3:0]             col_bits;
        logic                   dual_rank;
        logic [3:0]             byte_lanes;
        logic [`SPD_MTB_W-1:0]  mtb_ps;
        logic [7:0]             trcd;     // in mtb units
        logic [7:0]             trp;
        logic [11:0]            tras;
    } spd_params_t;

endpackage

/* spd_reader_sva.sv */
`timescale 1ns/1ns

module spd_reader_sva (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_req,
    input logic              i_ack,
    input spd_pkg::i2c_cmd_t i_cmd,
    input logic              i_done,
    input logic              i_err
);

    // a new request only once the previous ack was seen low
    a_req_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_req) |-> $past(!i_ack))
        else $error("req rose while ack was still high");

    a_cmd_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_req && $past(i_req)) |-> $stable(i_cmd))
        else $error("cmd changed while req was high");

    a_done_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_done && i_err))
        else $error("done and err both high");

endmodule

bind spd_reader_top spd_reader_sva u_sva (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (o_i2c_req),
    .i_ack   (i_i2c_ack),
    .i_cmd   (o_i2c_cmd),
    .i_done  (o_done),
    .i_err   (o_err)
);

/* spd_reader_top.sv */
`timescale 1ns/1ns
`include "spd_cfg.svh"

module spd_reader_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    output logic                 o_i2c_req,
    output spd_pkg::i2c_cmd_t    o_i2c_cmd,
    input  logic                 i_i2c_ack,
    input  spd_pkg::i2c_rsp_t    i_i2c_rsp,
    output logic                 o_done,
    output logic                 o_err,
    output spd_pkg::spd_params_t o_params
);

    logic                   cap_en;
    logic [`SPD_IDX_W-1:0]  cap_idx;
    logic [`SPD_DW-1:0]     cap_data;
    logic [`SPD_DEV_AW-1:0] dev_addr;
    logic                   div_start;
    logic                   mtb_done;
    logic [`SPD_MTB_W-1:0]  mtb_ps;
    spd_pkg::spd_bytes_t    bytes;

    spd_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .o_i2c_req   (o_i2c_req),
        .o_i2c_cmd   (o_i2c_cmd),
        .i_i2c_ack   (i_i2c_ack),
        .i_i2c_rsp   (i_i2c_rsp),
        .o_cap_en    (cap_en),
        .o_cap_idx   (cap_idx),
        .o_cap_data  (cap_data),
        .o_dev_addr  (dev_addr),
        .o_div_start (div_start),
        .o_err       (o_err)
    );

    spd_byte_regs u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cap_en   (cap_en),
        .i_cap_idx  (cap_idx),
        .i_cap_data (cap_data),
        .o_bytes    (bytes)
    );

    mtb_divider u_div (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (div_start),
        .i_dividend (bytes.mtb_dividend),
        .i_divisor  (bytes.mtb_divisor),
        .o_done     (mtb_done),
        .o_quot     (mtb_ps)
    );

    spd_decode u_dec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bytes    (bytes),
        .i_dev_addr (dev_addr),
        .i_mtb_done (mtb_done),
        .i_mtb_ps   (mtb_ps),
        .o_done     (o_done),
        .o_params   (o_params)
    );

endmodule

/* spd_sequencer.sv */
`timescale 1ns/1ns
`include "spd_cfg.svh"

module spd_sequencer (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    output logic                   o_i2c_req,
    output spd_pkg::i2c_cmd_t      o_i2c_cmd,
    input  logic                   i_i2c_ack,
    input  spd_pkg::i2c_rsp_t      i_i2c_rsp,
    output logic                   o_cap_en,
    output logic [`SPD_IDX_W-1:0]  o_cap_idx,
    output logic [`SPD_DW-1:0]     o_cap_data,
    output logic [`SPD_DEV_AW-1:0] o_dev_addr,
    output logic                   o_div_start,
    output logic                   o_err
);

    typedef enum logic [1:0] {
        ST_START,   // first request after reset
        ST_ACK,     // req high, waiting for ack
        ST_REL,     // req low, waiting for ack to drop
        ST_STOP
    } state_t;

    state_t                  state;
    logic                    reading;   // 0 while scanning addresses
    logic [`SPD_DEV_AW-1:0]  dev_addr;
    logic [`SPD_IDX_W-1:0]   byte_idx;

    // the scan reads register 0, byte_idx stays 0 until reading starts
    assign o_i2c_cmd.dev_addr = dev_addr;
    assign o_i2c_cmd.reg_addr = `SPD_REG_AW'(byte_idx);

    assign o_cap_en   = (state == ST_ACK) && reading && i_i2c_ack && !i_i2c_rsp.nack;
    assign o_cap_idx  = byte_idx;
    assign o_cap_data = i_i2c_rsp.data;
    assign o_dev_addr = dev_addr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_START;
            reading     <= 1'b0;
            dev_addr    <= `SPD_DEV_AW'(`SPD_ADDR_FIRST);
            byte_idx    <= '0;
            o_i2c_req   <= 1'b0;
            o_div_start <= 1'b0;
            o_err       <= 1'b0;
        end else begin
            o_div_start <= 1'b0;
            case (state)
                ST_START: begin
                    o_i2c_req <= 1'b1;
                    state     <= ST_ACK;
                end
                ST_ACK: if (i_i2c_ack) begin
                    o_i2c_req <= 1'b0;   // rsp is taken on this edge
                    state     <= ST_REL;
                    if (!reading) begin
                        if (!i_i2c_rsp.nack) begin
                            reading <= 1'b1;   // device found, keep its address
                        end else if (dev_addr == `SPD_DEV_AW'(`SPD_ADDR_LAST)) begin
                            o_err <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            dev_addr <= dev_addr + 1'b1;
                        end
                    end else if (i_i2c_rsp.nack) begin
                        o_err <= 1'b1;   // device went away mid read
                        state <= ST_STOP;
                    end else if (byte_idx == `SPD_IDX_W'(`SPD_LAST_BYTE)) begin
                        o_div_start <= 1'b1;
                        state       <= ST_STOP;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
                ST_REL: if (!i_i2c_ack) begin
                    o_i2c_req <= 1'b1;
                    state     <= ST_ACK;
                end
                default: state <= ST_STOP;
            endcase
        end
    end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
    input  logic i_rst_req,   // starts a new reset pulse
    output logic o_clk,
    output logic o_rst_n
);

    int cyc = 0;

    initial begin
        o_clk   = 1'b0;
        o_rst_n <= 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // reset stays low for 4 rising edges
    always @(posedge o_clk) begin
        if (i_rst_req)
            cyc <= 0;
        else if (cyc < 4)
            cyc <= cyc + 1;
    end

    always @(negedge o_clk) o_rst_n <= (cyc >= 4);   // released away from the rising edge

endmodule

/* tb_spd_reader.sv */
`timescale 1ns/1ns
`include "spd_cfg.svh"

module tb_spd_reader;

    typedef logic [`SPD_DW-1:0] image_t [0:`SPD_LAST_BYTE];

    logic                   clk;
    logic                   rst_n;
    logic                   rst_req = 1'b0;
    logic                   i2c_req;
    spd_pkg::i2c_cmd_t      i2c_cmd;
    logic                   i2c_ack = 1'b0;
    spd_pkg::i2c_rsp_t      i2c_rsp = '0;
    logic                   done;
    logic                   err;
    spd_pkg::spd_params_t   params;

    logic [31:0]            lfsr = 32'he866cfa6;
    image_t                 image;
    logic [`SPD_DEV_AW-1:0] model_addr = '0;   // 0 means no device on the bus
    int                     nack_byte = -1;
    logic                   pending = 1'b0;
    logic [1:0]             delay = '0;
    spd_pkg::i2c_cmd_t      cmd_log[$];
    spd_pkg::spd_params_t   exp_params = '0;
    logic                   done_seen = 1'b0;

    tb_clk_gen u_clk (.i_rst_req(rst_req), .o_clk(clk), .o_rst_n(rst_n));

    spd_reader_top dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .o_i2c_req (i2c_req),
        .o_i2c_cmd (i2c_cmd),
        .i_i2c_ack (i2c_ack),
        .i_i2c_rsp (i2c_rsp),
        .o_done    (done),
        .o_err     (err),
        .o_params  (params)
    );

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic spd_pkg::spd_params_t ref_params(input image_t img,
                                                       input logic [`SPD_DEV_AW-1:0] addr);
        spd_pkg::spd_params_t p;
        int                   mtb;
        p.dev_addr    = addr;
        p.is_ddr3     = (img[`SPD_BYTE_TYPE] == 8'h0B);
        p.module_type = img[`SPD_BYTE_MODULE][3:0];
        p.ba_bits     = img[`SPD_BYTE_DENSITY][6:4] + 4'd3;
        p.density     = img[`SPD_BYTE_DENSITY][3:0];
        p.row_bits    = img[`SPD_BYTE_ADDRESSING][5:3] + 5'd12;
        p.col_bits    = img[`SPD_BYTE_ADDRESSING][2:0] + 4'd9;   // wraps at 16
        p.dual_rank   = (img[`SPD_BYTE_ORG][5:3] == 3'd1);
        p.byte_lanes  = 4'd1 << img[`SPD_BYTE_BUSW][1:0];
        if (img[`SPD_BYTE_MTB_DIVISOR] == 8'h00) begin
            p.mtb_ps = '1;
        end else begin
            mtb      = int'(img[`SPD_BYTE_MTB_DIVIDEND]) * 1000
                       / int'(img[`SPD_BYTE_MTB_DIVISOR]);
            p.mtb_ps = mtb[`SPD_MTB_W-1:0];
        end
        p.trcd = img[`SPD_BYTE_TRCD];
        p.trp  = img[`SPD_BYTE_TRP];
        p.tras = {img[`SPD_BYTE_TRAS_HI][3:0], img[`SPD_BYTE_TRAS_LO]};
        return p;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            fail_run("stopping at the first mismatch");
        end
    endtask

    // eeprom behind the i2c master answers each request after a random delay
    always @(negedge clk) begin
        if (!rst_n) begin
            i2c_ack = 1'b0;
            pending = 1'b0;
        end else if (i2c_ack) begin
            if (!i2c_req)
                i2c_ack = 1'b0;
        end else if (i2c_req) begin
            if (!pending) begin
                pending = 1'b1;
                delay   = 2'(take_bits(2));
                cmd_log.push_back(i2c_cmd);
            end
            if (delay != 2'd0) begin
                delay = delay - 2'd1;
            end else begin
                pending      = 1'b0;
                i2c_rsp.nack = (model_addr == '0) || (i2c_cmd.dev_addr != model_addr)
                               || (int'(i2c_cmd.reg_addr) == nack_byte);
                if (i2c_rsp.nack || i2c_cmd.reg_addr > `SPD_LAST_BYTE)
                    i2c_rsp.data = 8'h00;
                else
                    i2c_rsp.data = image[i2c_cmd.reg_addr];
                i2c_ack = 1'b1;
            end
        end
    end

    // compare process checks o_params once per run when o_done rises
    always @(negedge clk) begin
        if (!rst_n) begin
            done_seen = 1'b0;
        end else if (done && !done_seen) begin
            done_seen = 1'b1;
            check_value("o_params", 96'(params), 96'(exp_params));
        end
    end

    task automatic start_run(input logic [`SPD_DEV_AW-1:0] addr, input int nack_idx,
                             input logic ddr3);
        int t;
        @(negedge clk);
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        t = 0;
        while (rst_n && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (rst_n)
            fail_run("reset did not assert");
        model_addr = addr;
        nack_byte  = nack_idx;
        for (int i = 0; i <= `SPD_LAST_BYTE; i++)
            image[i] = 8'(take_bits(8));
        if (image[`SPD_BYTE_MTB_DIVISOR] == 8'h00)
            image[`SPD_BYTE_MTB_DIVISOR] = 8'h01;
        if (ddr3)
            image[`SPD_BYTE_TYPE] = `SPD_DDR3_TYPE;
        else if (image[`SPD_BYTE_TYPE] == `SPD_DDR3_TYPE)
            image[`SPD_BYTE_TYPE] = 8'h0C;
        exp_params = ref_params(image, addr);
        cmd_log.delete();
        t = 0;
        while (!rst_n && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (!rst_n)
            fail_run("reset was not released");
    endtask

    task automatic wait_for_end();
        int t;
        t = 0;
        while (!done && !err) begin
            if (t == 5000)
                fail_run("timed out waiting for o_done or o_err");
            else begin
                @(negedge clk);
                t++;
            end
        end
    endtask

    task automatic wait_checked();
        int t;
        t = 0;
        while (!done_seen) begin
            if (t == 10)
                fail_run("o_params was never compared after o_done");
            else begin
                @(negedge clk);
                t++;
            end
        end
    endtask

    // scan requests 1..last_addr at register 0, then n_reads bytes at last_addr
    task automatic check_cmds(input int last_addr, input int n_reads);
        check_value("o_i2c_req count", cmd_log.size(), last_addr + n_reads);
        for (int a = 1; a <= last_addr; a++)
            check_value("o_i2c_cmd", cmd_log[a-1], {7'(a), 8'h00});
        for (int i = 0; i < n_reads; i++)
            check_value("o_i2c_cmd", cmd_log[last_addr+i], {7'(last_addr), 8'(i)});
    endtask

    initial begin
        start_run(7'h50, -1, 1'b1);
        wait_for_end();
        check_value("o_err", err, 0);
        wait_checked();
        check_cmds('h50, `SPD_LAST_BYTE + 1);

        start_run(7'h50, -1, 1'b0);   // not a ddr3 type byte
        wait_for_end();
        check_value("o_err", err, 0);
        wait_checked();
        check_cmds('h50, `SPD_LAST_BYTE + 1);

        start_run(7'h50, 5, 1'b1);   // device nacks byte 5
        wait_for_end();
        check_value("o_err", err, 1);
        repeat (40) @(negedge clk);
        check_value("o_done", done, 0);
        check_cmds('h50, 6);

        start_run('0, -1, 1'b1);
        wait_for_end();
        check_value("o_err", err, 1);
        check_value("o_done", done, 0);
        check_cmds(`SPD_ADDR_LAST, 0);

        $display("sim passed");
        $finish;
    end

endmodule
